// ==== dcache.f ====
+incdir+.
dcache_pkg.sv
dcache_ram.sv
dcache_repl.sv
dcache_datapath.sv
dcache_ctrl.sv
dcache_top.sv
dcache_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0 --timescale 1ns/100ps
TOP       := dcache_tb
FILELIST  := dcache.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(filter-out +%,$(shell cat $(FILELIST))) dcache_macros.svh

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf $(OBJ_DIR)

// ==== dcache_tb.sv ====
`include "dcache_macros.svh"

module dcache_tb
    import dcache_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam time SAMPLE  = 10ns;
    localparam int  TIMEOUT = 100;

    logic  clk;
    logic  rst;
    logic  req_valid_i;
    logic  req_write_i;
    addr_t req_addr_i;
    strb_t req_strb_i;
    word_t req_wdata_i;
    logic  stall_o;
    logic  data_ok_o;
    word_t rdata_o;
    logic  rd_req_o;
    addr_t rd_addr_o;
    logic  ret_valid_i;
    line_t ret_data_i;
    logic  wr_req_o;
    addr_t wr_addr_o;
    line_t wr_data_o;
    logic  wr_valid_i;

    int    value_errors = 0;
    int    other_errors = 0;
    int    rd_count = 0;
    int    wr_count = 0;
    int    ok_count = 0;
    int    model_rd = 0;
    int    model_wr = 0;
    int    delays [1024];
    int    dly_idx = 0;
    addr_t last_rd_addr;
    word_t last_rdata;

    // architectural memory and backing memory, keyed by word address
    word_t arch_mem [addr_t];
    word_t back_mem [addr_t];

    // expected read data in issue order
    word_t exp_q [$];
    string name_q [$];
    addr_t rd_addr_q [$];
    addr_t wb_addr_q [$];

    // tag, valid, dirty and lru per set
    tag_t  m_tag [`DCACHE_SETS][2];
    bit    m_valid [`DCACHE_SETS][2];
    bit    m_dirty [`DCACHE_SETS][2];
    bit    m_lru [`DCACHE_SETS];

    dcache_top dut_i (.*);

    always #50 clk = ~clk;

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    function automatic word_t fill_word(input addr_t a);
        return {a[15:0], a[31:16]} ^ 32'h5a3c_96e1;
    endfunction

    function automatic word_t expected_word(input addr_t addr);
        addr_t a;
        a = addr & ~32'h3;
        if (arch_mem.exists(a)) begin
            return arch_mem[a];
        end
        return fill_word(a);
    endfunction

    function automatic word_t back_word(input addr_t a);
        if (back_mem.exists(a)) begin
            return back_mem[a];
        end
        return fill_word(a);
    endfunction

    function automatic line_t expected_line(input addr_t base);
        line_t line;
        for (int i = 0; i <= `DCACHE_BURST_LEN; i++) begin
            line[32*i +: 32] = expected_word(base + 4*i);
        end
        return line;
    endfunction

    // byte-strobe merge
    function automatic void store_word(input addr_t addr, input strb_t strb, input word_t wdata);
        word_t cur;
        cur = expected_word(addr);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                cur[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        arch_mem[addr & ~32'h3] = cur;
    endfunction

    function automatic void update_model(input logic write, input addr_t addr);
        tag_t   t;
        index_t s;
        int     w;
        int     v;
        t = tag_t'(addr >> (`DCACHE_OFFSET_W + `DCACHE_INDEX_W));
        s = index_t'(addr >> `DCACHE_OFFSET_W);
        w = -1;
        for (int i = 0; i < 2; i++) begin
            if (m_valid[s][i] && m_tag[s][i] == t) begin
                w = i;
            end
        end
        if (w >= 0) begin
            m_lru[s] = (w == 0);
            if (write) begin
                m_dirty[s][w] = 1'b1;
            end
        end else begin
            v = m_lru[s] ? 1 : 0;
            if (m_valid[s][v] && m_dirty[s][v]) begin
                wb_addr_q.push_back({m_tag[s][v], s, 4'h0});
                model_wr++;
            end
            rd_addr_q.push_back({t, s, 4'h0});
            model_rd++;
            m_tag[s][v]   = t;
            m_valid[s][v] = 1'b1;
            m_dirty[s][v] = write;
            m_lru[s]      = (v == 0);
        end
    endfunction

    ////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            value_errors++;
            $display("[FAIL] %s: expected %08h, actual %08h", name, exp, act);
        end
    endtask

    task automatic check_line(input string name, input line_t exp, input line_t act);
        if (act !== exp) begin
            value_errors++;
            $display("[FAIL] %s: expected %032h, actual %032h", name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (act !== exp) begin
            value_errors++;
            $display("[FAIL] %s: expected %08h, actual %08h", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            value_errors++;
            $display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic finish_run();
        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    endtask

    task automatic abort_run(input string what);
        other_errors++;
        $display("timeout: %s", what);
        finish_run();
    endtask

    ////////////////////////////////////////
    // CPU side
    ////////////////////////////////////////

    task automatic issue(input logic write, input addr_t addr, input strb_t strb,
                         input word_t wdata, input string name);
        int waited;
        @(negedge clk);
        req_valid_i = 1'b1;
        req_write_i = write;
        req_addr_i  = addr;
        req_strb_i  = strb;
        req_wdata_i = wdata;
        #SAMPLE;
        waited = 0;
        while (stall_o) begin
            waited++;
            if (waited > TIMEOUT) begin
                abort_run({name, ": request was never accepted"});
            end
            @(negedge clk);
            #SAMPLE;
        end
        // accepted at the coming rising edge
        update_model(write, addr);
        if (write) begin
            store_word(addr, strb, wdata);
        end else begin
            exp_q.push_back(expected_word(addr));
            name_q.push_back(name);
        end
    endtask

    task automatic drain(input string name);
        int waited;
        @(negedge clk);
        req_valid_i = 1'b0;
        req_write_i = 1'b0;
        #SAMPLE;
        waited = 0;
        while (stall_o) begin
            waited++;
            if (waited > TIMEOUT) begin
                abort_run({name, ": stall_o stuck high"});
            end
            @(negedge clk);
            #SAMPLE;
        end
        @(negedge clk);
        #SAMPLE;
        if (exp_q.size() != 0) begin
            other_errors++;
            $display("%s: %0d reads never got data_ok_o", name, exp_q.size());
        end
        check_count({name, ": total rd_req"}, model_rd, rd_count);
        check_count({name, ": total wr_req"}, model_wr, wr_count);
    endtask

    task automatic access(input logic write, input addr_t addr, input strb_t strb,
                          input word_t wdata, input string name, input int exp_rd,
                          input int exp_wr);
        int rd0;
        int wr0;
        rd0 = rd_count;
        wr0 = wr_count;
        issue(write, addr, strb, wdata, name);
        drain(name);
        check_count({name, ": rd_req"}, exp_rd, rd_count - rd0);
        check_count({name, ": wr_req"}, exp_wr, wr_count - wr0);
    endtask

    // memory responder
    initial begin
        int    dly;
        addr_t base;
        forever begin
            @(negedge clk);
            ret_valid_i = 1'b0;
            wr_valid_i  = 1'b0;
            if (rst && wr_req_o) begin
                wr_count++;
                base = wr_addr_o;
                if (wb_addr_q.size() == 0) begin
                    other_errors++;
                    $display("write-back to %08h was not expected", base);
                end else begin
                    check_addr("write-back address", wb_addr_q.pop_front(), base);
                end
                check_line("write-back data", expected_line(base), wr_data_o);
                for (int i = 0; i <= `DCACHE_BURST_LEN; i++) begin
                    back_mem[base + 4*i] = wr_data_o[32*i +: 32];
                end
                dly = delays[dly_idx % 1024];
                dly_idx++;
                repeat (dly) @(negedge clk);
                wr_valid_i = 1'b1;
            end else if (rst && rd_req_o) begin
                rd_count++;
                base = rd_addr_o;
                last_rd_addr = base;
                if (rd_addr_q.size() == 0) begin
                    other_errors++;
                    $display("line read from %08h was not expected", base);
                end else begin
                    check_addr("refill address", rd_addr_q.pop_front(), base);
                end
                dly = delays[dly_idx % 1024];
                dly_idx++;
                repeat (dly) @(negedge clk);
                for (int i = 0; i <= `DCACHE_BURST_LEN; i++) begin
                    ret_data_i[32*i +: 32] = back_word(base + 4*i);
                end
                ret_valid_i = 1'b1;
            end
        end
    end

    // read data checker
    initial begin
        forever begin
            @(negedge clk);
            #SAMPLE;
            if (rst && data_ok_o) begin
                ok_count++;
                last_rdata = rdata_o;
                if (exp_q.size() == 0) begin
                    other_errors++;
                    $display("data_ok_o pulsed with no read outstanding");
                end else begin
                    check_word(name_q.pop_front(), exp_q.pop_front(), rdata_o);
                end
            end
        end
    end

    initial begin
        int    ok0;
        int    rd0;
        int    reads;
        logic  write;
        addr_t addr;
        word_t fill;
        void'($urandom(29274));
        clk         = 1'b0;
        rst         = 1'b0;
        req_valid_i = 1'b0;
        req_write_i = 1'b0;
        req_addr_i  = '0;
        req_strb_i  = '0;
        req_wdata_i = '0;
        ret_valid_i = 1'b0;
        ret_data_i  = '0;
        wr_valid_i  = 1'b0;
        for (int i = 0; i < 1024; i++) begin
            delays[i] = $urandom_range(1, 5);
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        #SAMPLE;
        if (stall_o || data_ok_o || rd_req_o || wr_req_o) begin
            other_errors++;
            $display("cache outputs are not idle after reset");
        end

        // one line read twice over, a single refill, first miss on the last word
        rd0 = rd_count;
        for (int r = 0; r < 2; r++) begin
            for (int w = 0; w < 4; w++) begin
                issue(1'b0, 32'h0001_243c - 4*w, 4'h0, '0, "repeated line read");
            end
        end
        drain("repeated line read");
        check_count("repeated line: rd_req", 1, rd_count - rd0);
        check_addr("repeated line: rd_addr", 32'h0001_2430, last_rd_addr);

        // A B A C evicts B
        access(1'b0, 32'h0010_0400, 4'h0, '0, "lru A", 1, 0);
        access(1'b0, 32'h0020_0400, 4'h0, '0, "lru B", 1, 0);
        access(1'b0, 32'h0010_0400, 4'h0, '0, "lru A again", 0, 0);
        access(1'b0, 32'h0030_0400, 4'h0, '0, "lru C", 1, 0);
        access(1'b0, 32'h0010_0400, 4'h0, '0, "lru A hit", 0, 0);
        access(1'b0, 32'h0020_0400, 4'h0, '0, "lru B miss", 1, 0);

        // dirty victim written back, clean one dropped
        access(1'b1, 32'h0040_0414, 4'hf, 32'hdead_beef, "evict write A", 1, 0);
        access(1'b0, 32'h0050_0410, 4'h0, '0, "evict read B", 1, 0);
        access(1'b0, 32'h0060_0410, 4'h0, '0, "evict dirty A", 1, 1);
        access(1'b0, 32'h0070_0410, 4'h0, '0, "evict clean B", 1, 0);

        // write miss with a partial strobe
        access(1'b1, 32'h0080_0428, 4'b0101, 32'h1122_3344, "write miss", 1, 0);
        access(1'b0, 32'h0080_0428, 4'h0, '0, "write miss readback", 0, 0);
        fill = fill_word(32'h0080_0428);
        check_word("write miss merge", {fill[31:24], 8'h22, fill[15:8], 8'h44}, last_rdata);
        access(1'b0, 32'h0080_042c, 4'h0, '0, "write miss neighbor", 0, 0);
        check_word("write miss neighbor word", fill_word(32'h0080_042c), last_rdata);

        // back-to-back hits on two resident lines
        access(1'b0, 32'h0090_0900, 4'h0, '0, "hit stream prime 0", 1, 0);
        access(1'b0, 32'h00a0_0900, 4'h0, '0, "hit stream prime 1", 1, 0);
        ok0   = ok_count;
        rd0   = rd_count;
        reads = 0;
        for (int i = 0; i < 40; i++) begin
            addr  = ($urandom_range(0, 1) == 1) ? 32'h00a0_0900 : 32'h0090_0900;
            addr  = addr + 4 * $urandom_range(0, 3);
            write = ($urandom_range(0, 3) == 0);
            if (!write) begin
                reads++;
            end
            issue(write, addr, strb_t'($urandom), $urandom, "hit stream");
        end
        drain("hit stream");
        check_count("hit stream: data_ok", reads, ok_count - ok0);
        check_count("hit stream: rd_req", 0, rd_count - rd0);

        // random mix over four sets, four tags each
        for (int i = 0; i < 300; i++) begin
            addr = {tag_t'(32'h10 + $urandom_range(0, 3)),
                    index_t'(32'h80 + $urandom_range(0, 3)), 4'h0};
            addr  = addr + 4 * $urandom_range(0, 3);
            write = ($urandom_range(0, 1) == 1);
            issue(write, addr, strb_t'($urandom), $urandom, "random mix");
        end
        drain("random mix");

        finish_run();
    end

endmodule

// ==== dcache_top.sv ====
`include "dcache_macros.svh"

module dcache_top
    import dcache_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  req_valid_i,
    input  logic  req_write_i,
    input  addr_t req_addr_i,
    input  strb_t req_strb_i,
    input  word_t req_wdata_i,
    output logic  stall_o,
    output logic  data_ok_o,
    output word_t rdata_o,
    output logic  rd_req_o,
    output addr_t rd_addr_o,
    input  logic  ret_valid_i,
    input  line_t ret_data_i,
    output logic  wr_req_o,
    output addr_t wr_addr_o,
    output line_t wr_data_o,
    input  logic  wr_valid_i
);

    logic    s2_valid;
    tag_t    s2_tag;
    index_t  s2_index;
    offset_t s2_offset;
    logic    s2_write;
    strb_t   s2_strb;
    word_t   s2_wdata;
    index_t  rd_index;
    tagv_t   tagv_q [2];
    line_t   line_q [2];
    logic    way_we [2];
    logic    hit;
    way_t    hit_way;
    way_t    victim;
    logic    victim_dirty;
    tag_t    victim_tag;
    line_t   victim_line;
    line_t   wline;
    logic    refill;

    // tag/valid array and line array per way
    for (genvar w = 0; w < 2; w++) begin : g_way
        dcache_ram #(
            .payload_t (tagv_t),
            .DEPTH     (`DCACHE_SETS)
        ) tagv_ram_i (
            .clk        (clk),
            .rd_index_i (rd_index),
            .rd_data_o  (tagv_q[w]),
            .we_i       (way_we[w]),
            .wr_index_i (s2_index),
            .wr_data_i  ({1'b1, s2_tag})
        );

        dcache_ram #(
            .payload_t (line_t),
            .DEPTH     (`DCACHE_SETS)
        ) line_ram_i (
            .clk        (clk),
            .rd_index_i (rd_index),
            .rd_data_o  (line_q[w]),
            .we_i       (way_we[w]),
            .wr_index_i (s2_index),
            .wr_data_i  (wline)
        );
    end

    dcache_repl repl_i (
        .clk            (clk),
        .rst            (rst),
        .index_i        (s2_index),
        .hit_i          (hit),
        .hit_way_i      (hit_way),
        .write_i        (s2_write),
        .refill_i       (refill),
        .refill_write_i (s2_write),
        .victim_o       (victim),
        .victim_dirty_o (victim_dirty)
    );

    dcache_datapath datapath_i (
        .valid_i       (s2_valid),
        .tag_i         (s2_tag),
        .offset_i      (s2_offset),
        .write_i       (s2_write),
        .strb_i        (s2_strb),
        .wdata_i       (s2_wdata),
        .tagv0_i       (tagv_q[0]),
        .tagv1_i       (tagv_q[1]),
        .line0_i       (line_q[0]),
        .line1_i       (line_q[1]),
        .ret_data_i    (ret_data_i),
        .refill_i      (refill),
        .victim_i      (victim),
        .hit_o         (hit),
        .hit_way_o     (hit_way),
        .rdata_o       (rdata_o),
        .wline_o       (wline),
        .victim_line_o (victim_line),
        .victim_tag_o  (victim_tag)
    );

    dcache_ctrl ctrl_i (
        .clk            (clk),
        .rst            (rst),
        .req_valid_i    (req_valid_i),
        .req_write_i    (req_write_i),
        .req_addr_i     (req_addr_i),
        .req_strb_i     (req_strb_i),
        .req_wdata_i    (req_wdata_i),
        .stall_o        (stall_o),
        .data_ok_o      (data_ok_o),
        .valid_o        (s2_valid),
        .tag_o          (s2_tag),
        .index_o        (s2_index),
        .offset_o       (s2_offset),
        .write_o        (s2_write),
        .strb_o         (s2_strb),
        .wdata_o        (s2_wdata),
        .rd_index_o     (rd_index),
        .hit_i          (hit),
        .hit_way_i      (hit_way),
        .victim_i       (victim),
        .victim_dirty_i (victim_dirty),
        .victim_tag_i   (victim_tag),
        .victim_line_i  (victim_line),
        .we0_o          (way_we[0]),
        .we1_o          (way_we[1]),
        .refill_o       (refill),
        .rd_req_o       (rd_req_o),
        .rd_addr_o      (rd_addr_o),
        .ret_valid_i    (ret_valid_i),
        .wr_req_o       (wr_req_o),
        .wr_addr_o      (wr_addr_o),
        .wr_data_o      (wr_data_o),
        .wr_valid_i     (wr_valid_i)
    );

endmodule

// ==== dcache_ctrl.sv ====
`include "dcache_macros.svh"

module dcache_ctrl
    import dcache_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    req_valid_i,
    input  logic    req_write_i,
    input  addr_t   req_addr_i,
    input  strb_t   req_strb_i,
    input  word_t   req_wdata_i,
    output logic    stall_o,
    output logic    data_ok_o,
    output logic    valid_o,
    output tag_t    tag_o,
    output index_t  index_o,
    output offset_t offset_o,
    output logic    write_o,
    output strb_t   strb_o,
    output word_t   wdata_o,
    output index_t  rd_index_o,
    input  logic    hit_i,
    input  way_t    hit_way_i,
    input  way_t    victim_i,
    input  logic    victim_dirty_i,
    input  tag_t    victim_tag_i,
    input  line_t   victim_line_i,
    output logic    we0_o,
    output logic    we1_o,
    output logic    refill_o,
    output logic    rd_req_o,
    output addr_t   rd_addr_o,
    input  logic    ret_valid_i,
    output logic    wr_req_o,
    output addr_t   wr_addr_o,
    output line_t   wr_data_o,
    input  logic    wr_valid_i
);

    ctrl_state_t state;
    ctrl_state_t state_nxt;
    logic        miss;
    logic        wr_hit;

    ////////////////////////////////////////
    // stage 2 request register
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            valid_o <= 1'b0;
            write_o <= 1'b0;
        end else if (!stall_o) begin
            valid_o <= req_valid_i;
            write_o <= req_write_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_o) begin
            tag_o    <= req_addr_i[`DCACHE_OFFSET_W + `DCACHE_INDEX_W +: `DCACHE_TAG_W];
            index_o  <= req_addr_i[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];
            offset_o <= req_addr_i[`DCACHE_OFFSET_W-1:0];
            strb_o   <= req_strb_i;
            wdata_o  <= req_wdata_i;
        end
    end

    // keep re-reading the stalled set so the array outputs hold
    assign rd_index_o = stall_o ? index_o : req_addr_i[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];

    ////////////////////////////////////////
    // miss FSM
    ////////////////////////////////////////

    assign miss = valid_o && !hit_i;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (miss) begin
                    state_nxt = victim_dirty_i ? WRITEBACK : REFILL;
                end
            end
            WRITEBACK: begin
                if (wr_valid_i) begin
                    state_nxt = REFILL;
                end
            end
            REFILL: begin
                if (ret_valid_i) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_comb begin
        case (state)
            IDLE:      stall_o = miss;
            WRITEBACK: stall_o = 1'b1;
            REFILL:    stall_o = !ret_valid_i;
            default:   stall_o = 1'b0;
        endcase
    end

    assign refill_o  = (state == REFILL) && ret_valid_i;
    assign wr_hit    = hit_i && write_o && (state == IDLE);
    assign data_ok_o = valid_o && !write_o && (((state == IDLE) && hit_i) || refill_o);

    // hit writes go to the hit way, refills to the victim
    assign we0_o = (wr_hit && (hit_way_i == 1'b0)) || (refill_o && (victim_i == 1'b0));
    assign we1_o = (wr_hit && (hit_way_i == 1'b1)) || (refill_o && (victim_i == 1'b1));

    ////////////////////////////////////////
    // memory requests
    ////////////////////////////////////////

    assign rd_req_o  = (state == REFILL);
    assign rd_addr_o = {tag_o, index_o, {`DCACHE_OFFSET_W{1'b0}}};

    assign wr_req_o  = (state == WRITEBACK);
    assign wr_addr_o = {victim_tag_i, index_o, {`DCACHE_OFFSET_W{1'b0}}};
    assign wr_data_o = victim_line_i;

endmodule

// ==== dcache_datapath.sv ====
`include "dcache_macros.svh"

module dcache_datapath
    import dcache_pkg::*;
(
    input  logic    valid_i,
    input  tag_t    tag_i,
    input  offset_t offset_i,
    input  logic    write_i,
    input  strb_t   strb_i,
    input  word_t   wdata_i,
    input  tagv_t   tagv0_i,
    input  tagv_t   tagv1_i,
    input  line_t   line0_i,
    input  line_t   line1_i,
    input  line_t   ret_data_i,
    input  logic    refill_i,
    input  way_t    victim_i,
    output logic    hit_o,
    output way_t    hit_way_o,
    output word_t   rdata_o,
    output line_t   wline_o,
    output line_t   victim_line_o,
    output tag_t    victim_tag_o
);

    localparam int WSEL_W = $clog2(`DCACHE_LINE_WORDS);

    logic              hit0;
    logic              hit1;
    logic [WSEL_W-1:0] wsel;
    line_t             base_line;
    word_t             base_word;
    word_t             byte_mask;

    ////////////////////////////////////////
    // tag compare
    ////////////////////////////////////////

    assign hit0      = tagv0_i.valid && (tagv0_i.tag == tag_i);
    assign hit1      = tagv1_i.valid && (tagv1_i.tag == tag_i);
    assign hit_o     = valid_i && (hit0 || hit1);
    assign hit_way_o = way_t'(hit1);

    ////////////////////////////////////////
    // word select and merge
    ////////////////////////////////////////

    assign wsel = offset_i[`DCACHE_OFFSET_W-1 -: WSEL_W];

    // refill line wins over the array contents
    assign base_line = refill_i ? ret_data_i : (hit1 ? line1_i : line0_i);
    assign base_word = base_line[wsel*`DCACHE_WORD_W +: `DCACHE_WORD_W];
    assign rdata_o   = base_word;

    always_comb begin
        for (int b = 0; b < `DCACHE_WORD_W/8; b++) begin
            byte_mask[b*8 +: 8] = {8{strb_i[b]}};
        end
    end

    always_comb begin
        wline_o = base_line;
        if (write_i) begin
            // only strobed bytes change
            wline_o[wsel*`DCACHE_WORD_W +: `DCACHE_WORD_W] =
                (wdata_i & byte_mask) | (base_word & ~byte_mask);
        end
    end

    // line and tag of the way picked for eviction
    assign victim_line_o = victim_i ? line1_i : line0_i;
    assign victim_tag_o  = victim_i ? tagv1_i.tag : tagv0_i.tag;

endmodule

// ==== dcache_repl.sv ====
`include "dcache_macros.svh"

module dcache_repl
    import dcache_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  index_t index_i,
    input  logic   hit_i,
    input  way_t   hit_way_i,
    input  logic   write_i,
    input  logic   refill_i,
    input  logic   refill_write_i,
    output way_t   victim_o,
    output logic   victim_dirty_o
);

    // one bit per set names the least recently used way
    logic [`DCACHE_SETS-1:0] lru;
    logic [`DCACHE_SETS-1:0] dirty0;
    logic [`DCACHE_SETS-1:0] dirty1;

    assign victim_o       = lru[index_i];
    assign victim_dirty_o = victim_o ? dirty1[index_i] : dirty0[index_i];

    always_ff @(posedge clk) begin
        if (!rst) begin
            lru <= '0;
        end else if (hit_i) begin
            // the way not touched becomes the victim
            lru[index_i] <= ~hit_way_i;
        end else if (refill_i) begin
            lru[index_i] <= ~victim_o;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            dirty0 <= '0;
            dirty1 <= '0;
        end else if (hit_i && write_i) begin
            if (hit_way_i) begin
                dirty1[index_i] <= 1'b1;
            end else begin
                dirty0[index_i] <= 1'b1;
            end
        end else if (refill_i) begin
            // write miss leaves the new line dirty
            if (victim_o) begin
                dirty1[index_i] <= refill_write_i;
            end else begin
                dirty0[index_i] <= refill_write_i;
            end
        end
    end

endmodule

// ==== dcache_ram.sv ====
module dcache_ram #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 256
) (
    input  logic                     clk,
    input  logic [$clog2(DEPTH)-1:0] rd_index_i,
    output payload_t                 rd_data_o,
    input  logic                     we_i,
    input  logic [$clog2(DEPTH)-1:0] wr_index_i,
    input  payload_t                 wr_data_i
);

    payload_t mem [DEPTH];

    // power-up contents all zero, so every valid bit starts low
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always @(posedge clk) begin
        if (we_i) begin
            mem[wr_index_i] <= wr_data_i;
        end
    end

    // write-first: same-index read sees the new entry
    always_ff @(posedge clk) begin
        if (we_i && (wr_index_i == rd_index_i)) begin
            rd_data_o <= wr_data_i;
        end else begin
            rd_data_o <= mem[rd_index_i];
        end
    end

endmodule

// ==== dcache_pkg.sv ====
`include "dcache_macros.svh"

package dcache_pkg;

    typedef logic [31:0] addr_t;

    // address fields
    typedef logic [`DCACHE_TAG_W-1:0]    tag_t;
    typedef logic [`DCACHE_INDEX_W-1:0]  index_t;
    typedef logic [`DCACHE_OFFSET_W-1:0] offset_t;

    typedef logic [`DCACHE_WORD_W-1:0]   word_t;
    typedef logic [`DCACHE_WORD_W/8-1:0] strb_t;

    // word 0 sits in the low bits
    typedef logic [`DCACHE_LINE_WORDS*`DCACHE_WORD_W-1:0] line_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } tagv_t;

    typedef enum logic [1:0] {
        IDLE,
        WRITEBACK,
        REFILL
    } ctrl_state_t;

    typedef logic way_t;

endpackage

// ==== dcache_macros.svh ====
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

////////////////////////////////////////
// address split: tag | index | offset
////////////////////////////////////////

`define DCACHE_TAG_W      20
`define DCACHE_INDEX_W    8
`define DCACHE_OFFSET_W   4

////////////////////////////////////////
// geometry
////////////////////////////////////////

`define DCACHE_WORD_W     32
`define DCACHE_LINE_WORDS 4
`define DCACHE_SETS       256

// beats per line minus one, line-aligned bursts
`define DCACHE_BURST_LEN  3

`endif
